//--- rk_cfg.svh
`ifndef RK_CFG_SVH
`define RK_CFG_SVH

//////////////////////////////////////////////////
// state vector
//////////////////////////////////////////////////

`define RK_DIM     6   // x y z vx vy vz

//////////////////////////////////////////////////
// fixed point format
//////////////////////////////////////////////////

`define RK_FIX_W   32  // signed value width
`define RK_FRAC    16  // fraction bits
`define RK_SUM_W   35  // k1 + 2k2 + 2k3 + k4, weight 6
`define RK_PROD_W  67  // sum times step_6

// request to result, in cycles
`define RK_LAT     4

`endif

//--- rk_fix_pkg.sv
`include "rk_cfg.svh"

package rk_fix_pkg;

  //////////////////////////////////////////////////
  // numeric types of the combine datapath
  //////////////////////////////////////////////////

  // one state or slope component, Q15.16
  typedef logic signed [`RK_FIX_W-1:0] fix_t;

  // weighted slope sum, room for a total weight of 6
  typedef logic signed [`RK_SUM_W-1:0] slope_sum_t;

  // full product of the sum and step_6
  typedef logic signed [`RK_PROD_W-1:0] prod_t;

endpackage

//--- rk_bus_pkg.sv
`include "rk_cfg.svh"

package rk_bus_pkg;

  import rk_fix_pkg::*;

  //////////////////////////////////////////////////
  // vectors and handshake payloads
  //////////////////////////////////////////////////

  // one value per state component, index 0 is x
  typedef fix_t [`RK_DIM-1:0] fix_vec_t;

  // one full request from the caller
  typedef struct packed {
    fix_vec_t state;   // old state
    fix_vec_t k1;      // slope at start
    fix_vec_t k2;      // first midpoint slope
    fix_vec_t k3;      // second midpoint slope
    fix_vec_t k4;      // slope at end
    fix_t     step_6;  // h/6
  } rk_request_t;

  // operands for a single component lane
  typedef struct packed {
    fix_t state;
    fix_t k1;
    fix_t k2;
    fix_t k3;
    fix_t k4;
    fix_t step_6;
  } lane_operand_t;

  // output record
  typedef struct packed {
    fix_vec_t state;   // new state
  } rk_result_t;

endpackage

//--- rk_dispatch.sv
`include "rk_cfg.svh"

module rk_dispatch (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  rk_bus_pkg::rk_request_t   in_req,
  input  logic                      advance,
  output logic                      in_ready,
  output rk_bus_pkg::lane_operand_t lane_op [`RK_DIM],
  output logic                      op_valid
);

  import rk_bus_pkg::*;

  rk_request_t req_q;  // accepted request

  // the whole pipeline moves together, so the input side follows it
  assign in_ready = advance;

  //////////////////////////////////////////////////
  // stage 0 register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      op_valid <= 1'b0;
    end
    else if (advance)
    begin
      op_valid <= in_valid;  // bubble when nothing offered
    end
  end

  always_ff @(posedge clk)
  begin
    if (advance && in_valid)
    begin
      req_q <= in_req;
    end
  end

  //////////////////////////////////////////////////
  // split into per-component operands
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < `RK_DIM; i++)
    begin
      lane_op[i].state  = req_q.state[i];
      lane_op[i].k1     = req_q.k1[i];
      lane_op[i].k2     = req_q.k2[i];
      lane_op[i].k3     = req_q.k3[i];
      lane_op[i].k4     = req_q.k4[i];
      lane_op[i].step_6 = req_q.step_6;  // shared by all lanes
    end
  end

endmodule

//--- rk_lane.sv
`include "rk_cfg.svh"

module rk_lane (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      advance,
  input  rk_bus_pkg::lane_operand_t op,
  output rk_fix_pkg::fix_t          lane_res
);

  import rk_fix_pkg::*;

  // clamp limits of the result
  localparam fix_t FIX_MAX = {1'b0, {(`RK_FIX_W-1){1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {(`RK_FIX_W-1){1'b0}}};

  slope_sum_t sum_d;    // weighted slopes, comb
  slope_sum_t sum_q;
  fix_t       state_q;  // state delayed to match the sum
  fix_t       step_q;   // step_6 delayed likewise

  prod_t      prod;     // sum * step_6
  prod_t      scaled;   // back to 16 fraction bits
  prod_t      total;    // scaled + state, wide
  fix_t       sat;      // clamped result
  fix_t       res_q;

  //////////////////////////////////////////////////
  // stage 1: k1 + 2*k2 + 2*k3 + k4
  //////////////////////////////////////////////////

  always_comb
  begin
    sum_d = slope_sum_t'(op.k1)
          + (slope_sum_t'(op.k2) <<< 1)  // times two
          + (slope_sum_t'(op.k3) <<< 1)
          + slope_sum_t'(op.k4);
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      sum_q   <= '0;
      state_q <= '0;
      step_q  <= '0;
    end
    else if (advance)
    begin
      sum_q   <= sum_d;
      state_q <= op.state;
      step_q  <= op.step_6;
    end
  end

  //////////////////////////////////////////////////
  // stage 2: scale by h/6, add state, saturate
  //////////////////////////////////////////////////

  always_comb
  begin
    prod   = prod_t'(sum_q) * prod_t'(step_q);
    scaled = prod >>> `RK_FRAC;  // truncates toward minus infinity
    total  = scaled + prod_t'(state_q);
    if (total > prod_t'(FIX_MAX))
    begin
      sat = FIX_MAX;
    end
    else if (total < prod_t'(FIX_MIN))
    begin
      sat = FIX_MIN;
    end
    else
    begin
      sat = fix_t'(total);
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      res_q <= '0;
    end
    else if (advance)
    begin
      res_q <= sat;
    end
  end

  assign lane_res = res_q;

endmodule

//--- rk_collect.sv
`include "rk_cfg.svh"

module rk_collect (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   op_valid,
  input  rk_fix_pkg::fix_t       lane_res [`RK_DIM],
  input  logic                   out_ready,
  output logic                   advance,
  output logic                   out_valid,
  output rk_bus_pkg::rk_result_t out_res
);

  import rk_bus_pkg::*;

  logic       s1_valid;  // lane stage 1 holds an item
  logic       s2_valid;  // lane stage 2 holds an item
  rk_result_t res_next;

  //////////////////////////////////////////////////
  // global enable
  //////////////////////////////////////////////////

  // output slot free or being drained this cycle
  assign advance = !out_valid || out_ready;

  //////////////////////////////////////////////////
  // valid tracking, one bit per lane stage
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end
    else if (advance)
    begin
      s1_valid  <= op_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  //////////////////////////////////////////////////
  // result assembly and output register
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < `RK_DIM; i++)
    begin
      res_next.state[i] = lane_res[i];
    end
  end

  // held while advance is low, so stable under back-pressure
  always_ff @(posedge clk)
  begin
    if (advance && s2_valid)
    begin
      out_res <= res_next;
    end
  end

endmodule

//--- rk_combine_top.sv
`include "rk_cfg.svh"

module rk_combine_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  rk_bus_pkg::rk_request_t in_req,
  output logic                    in_ready,
  output logic                    out_valid,
  output rk_bus_pkg::rk_result_t  out_res,
  input  logic                    out_ready
);

  import rk_fix_pkg::*;
  import rk_bus_pkg::*;

  logic          advance;               // pipeline enable
  logic          op_valid;              // stage 0 valid
  lane_operand_t lane_op  [`RK_DIM];   // dispatcher to lanes
  fix_t          lane_res [`RK_DIM];   // lanes to collector

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  rk_dispatch i_rk_dispatch (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_req   (in_req),
    .advance  (advance),
    .in_ready (in_ready),
    .lane_op  (lane_op),
    .op_valid (op_valid)
  );

  //////////////////////////////////////////////////
  // one lane per state component
  //////////////////////////////////////////////////

  for (genvar g = 0; g < `RK_DIM; g++)
  begin : g_lane
    rk_lane i_rk_lane (
      .clk      (clk),
      .rst      (rst),
      .advance  (advance),
      .op       (lane_op[g]),
      .lane_res (lane_res[g])
    );
  end

  //////////////////////////////////////////////////
  // result side
  //////////////////////////////////////////////////

  rk_collect i_rk_collect (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .lane_res  (lane_res),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

endmodule

//--- rk_combine_props.sv
`include "rk_cfg.svh"

module rk_combine_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_valid,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input rk_bus_pkg::rk_result_t out_res
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // failed assertions so far

  // output register empty while reset is held
  a_idle_in_reset: assert property (@(posedge clk) !rst |-> !out_valid)
    else
    begin
      fail_cnt++;
      $error("out_valid high during reset");
    end

  // held result must not move or vanish
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
    out_valid && !out_ready |=> out_valid && $stable(out_res))
    else
    begin
      fail_cnt++;
      $error("out_valid or out_res changed under back-pressure");
    end

  // accept at T, drained freely, result visible at T+RK_LAT
  a_latency: assert property (@(posedge clk) disable iff (!rst)
    $past(in_valid && in_ready, `RK_LAT) && $past(out_ready, 1)
      && $past(out_ready, 2) && $past(out_ready, 3) |-> out_valid)
    else
    begin
      fail_cnt++;
      $error("result missing RK_LAT cycles after acceptance");
    end

endmodule

bind rk_combine_top rk_combine_props i_rk_combine_props (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_res   (out_res)
);

//--- tb_rk_combine.sv
`include "rk_cfg.svh"

module tb_rk_combine;

  timeunit 1ns;
  timeprecision 1ps;

  import rk_bus_pkg::*;

  localparam int N_REQ = 110;                     // upper bound of requests sent
  localparam longint WATCHDOG_NS = (N_REQ * 20 + 200) * 100;
  localparam longint FIX_MAX_L = 64'sh7fffffff;
  localparam longint FIX_MIN_L = -64'sh80000000;

  logic        clk;
  logic        rst;
  logic        in_valid;
  rk_request_t in_req;
  logic        in_ready;
  logic        out_valid;
  rk_result_t  out_res;
  logic        out_ready;

  integer   seed;
  int       errors;
  int       cycle;
  logic     bp_mode;      // random out_ready
  logic     burst_mode;   // stalls not allowed
  logic     lat_mode;     // check result latency
  fix_vec_t exp_q [$];
  int       acc_q [$];    // acceptance cycles
  logic     hold_pending;
  rk_result_t held_res;

  rk_combine_top i_rk_combine_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_res   (out_res),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk;

  // expected new state, straight from the update rule
  function automatic fix_vec_t expect_state(rk_request_t r);
    logic signed [31:0]  st;
    logic signed [31:0]  a;
    logic signed [31:0]  b;
    logic signed [31:0]  c;
    logic signed [31:0]  d;
    logic signed [31:0]  h;
    logic signed [127:0] sum;
    logic signed [127:0] tot;
    fix_vec_t            res;
    h = r.step_6;
    for (int i = 0; i < `RK_DIM; i++)
    begin
      st  = r.state[i];
      a   = r.k1[i];
      b   = r.k2[i];
      c   = r.k3[i];
      d   = r.k4[i];
      sum = 128'(a) + 2 * 128'(b) + 2 * 128'(c) + 128'(d);
      tot = ((sum * 128'(h)) >>> 16) + 128'(st);   // floor of the scaled term
      if (tot > FIX_MAX_L)
        res[i] = 32'h7fffffff;
      else if (tot < FIX_MIN_L)
        res[i] = 32'h80000000;
      else
        res[i] = tot[31:0];
    end
    return res;
  endfunction

  function automatic rk_request_t random_req();
    rk_request_t r;
    for (int i = 0; i < `RK_DIM; i++)
    begin
      r.state[i] = $random(seed);
      r.k1[i]    = $random(seed) >>> 4;   // mostly in range
      r.k2[i]    = $random(seed) >>> 4;
      r.k3[i]    = $random(seed) >>> 4;
      r.k4[i]    = $random(seed) >>> 4;
    end
    r.step_6 = $random(seed) >>> 12;
    return r;
  endfunction

  // drive one request, starting and ending on a falling edge
  task automatic send_req(input rk_request_t r);
    in_valid = 1'b1;
    in_req   = r;
    @(posedge clk);
    while (!in_ready)
    begin
      if (burst_mode)
      begin
        $display("ERROR at %0t: in_ready dropped during back-to-back burst", $time);
        errors++;
      end
      @(posedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    fix_vec_t exp_v;
    int       acc;
    if (rst)
    begin
      cycle++;
      if (hold_pending && out_res !== held_res)
      begin
        $display("FAIL at %0t: out_res expected %h actual %h", $time, held_res, out_res);
        errors++;
      end
      if (hold_pending && !out_valid)
      begin
        $display("ERROR at %0t: out_valid dropped while result was held", $time);
        errors++;
      end
      hold_pending = out_valid && !out_ready;
      held_res     = out_res;
      if (in_valid && in_ready)
      begin
        exp_q.push_back(expect_state(in_req));
        acc_q.push_back(cycle);
      end
      if (out_valid && out_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("ERROR at %0t: result appeared with no request outstanding", $time);
          errors++;
        end
        else
        begin
          exp_v = exp_q.pop_front();
          acc   = acc_q.pop_front();
          for (int i = 0; i < `RK_DIM; i++)
          begin
            if (out_res.state[i] !== exp_v[i])
            begin
              $display("FAIL at %0t: out_res.state[%0d] expected %h actual %h",
                       $time, i, exp_v[i], out_res.state[i]);
              errors++;
            end
          end
          if (lat_mode && cycle - acc != `RK_LAT)
          begin
            $display("FAIL at %0t: latency expected %0d actual %0d",
                     $time, `RK_LAT, cycle - acc);
            errors++;
          end
        end
      end
    end
  end

  // random back-pressure
  always @(negedge clk)
  begin
    if (bp_mode)
      out_ready = 1'($random(seed));
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("ERROR: simulation did not finish in time, results are still missing");
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    rk_request_t r;
    seed         = 32'h194;
    errors       = 0;
    cycle        = 0;
    clk          = 1'b0;
    rst          = 1'b0;
    in_valid     = 1'b0;
    in_req       = '0;
    out_ready    = 1'b1;
    bp_mode      = 1'b0;
    burst_mode   = 1'b0;
    lat_mode     = 1'b0;
    hold_pending = 1'b0;
    held_res     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    if (!in_ready || out_valid)
    begin
      $display("ERROR at %0t: pipeline not idle after reset", $time);
      errors++;
    end

    // latency on an idle pipeline
    lat_mode = 1'b1;
    send_req(random_req());
    drain();
    lat_mode = 1'b0;

    // zero slopes keep the state
    for (int n = 0; n < 4; n++)
    begin
      r = random_req();
      r.k1 = '0;
      r.k2 = '0;
      r.k3 = '0;
      r.k4 = '0;
      send_req(r);
    end
    drain();

    // random values
    for (int n = 0; n < 40; n++)
      send_req(random_req());
    drain();

    // saturation both ways
    for (int n = 0; n < 4; n++)
    begin
      r = random_req();
      for (int i = 0; i < `RK_DIM; i++)
      begin
        r.k1[i] = (n[0]) ? 32'h80010000 : 32'h7fff0000;
        r.k2[i] = r.k1[i];
        r.k3[i] = r.k1[i];
        r.k4[i] = r.k1[i];
      end
      r.step_6 = 32'h7fff0000;
      send_req(r);
    end
    drain();

    // throughput burst
    burst_mode = 1'b1;
    for (int n = 0; n < 16; n++)
      send_req(random_req());
    burst_mode = 1'b0;
    drain();

    // back-pressure
    bp_mode = 1'b1;
    for (int n = 0; n < 40; n++)
      send_req(random_req());
    drain();
    bp_mode   = 1'b0;
    out_ready = 1'b1;
    repeat (4) @(negedge clk);

    // failed assertions of the bound checker
    errors += i_rk_combine_top.i_rk_combine_props.fail_cnt;
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
rk_fix_pkg.sv
rk_bus_pkg.sv
rk_dispatch.sv
rk_lane.sv
rk_collect.sv
rk_combine_top.sv
rk_combine_props.sv
tb_rk_combine.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = tb_rk_combine
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
